/* design/aesKeyPkg.sv */
// Shared types and functions for the AES-128 key expansion engine
// S-box is a fixed forward table, inverse S-box not provided
// Rcon covers rounds 1 to 10 only and returns zero otherwise
package aesKeyPkg;

  // ------------------------------------------------------------------
  // Word and round types
  // ------------------------------------------------------------------

  // One 32-bit key word
  typedef logic [31:0] keyWordT;

  // Key word seen as a whole or as bytes, byte 0 most significant
  typedef union packed {
    keyWordT          word;
    logic [0:3][7:0]  bytes;
  } keyWordU;

  // Round number, 0 to 10
  typedef logic [3:0] roundIdxT;

  // Final AES-128 round
  localparam roundIdxT lastRound = roundIdxT'(10);

  // Round key output bundle, key word 0 most significant
  typedef struct packed {
    logic              valid;
    logic              done;
    roundIdxT          roundIdx;
    keyWordT [0:3]     key;
  } roundKeyS;

  // Controller strobes to the datapath
  typedef struct packed {
    logic        load;
    logic        enable;
    logic [7:0]  rcon;
  } ctrlS;

  // ------------------------------------------------------------------
  // S-box and Rcon
  // ------------------------------------------------------------------

  // Forward S-box, entry 0 in the leftmost byte
  localparam logic [0:255][7:0] sBoxTable = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  // Single byte through the S-box
  function automatic logic [7:0] sboxByte(input logic [7:0] inByte);
    return sBoxTable[inByte];
  endfunction

  // Round constant, powers of x in GF(2^8)
  function automatic logic [7:0] rconOf(input roundIdxT round);
    case (round)
      4'd1:    return 8'h01;
      4'd2:    return 8'h02;
      4'd3:    return 8'h04;
      4'd4:    return 8'h08;
      4'd5:    return 8'h10;
      4'd6:    return 8'h20;
      4'd7:    return 8'h40;
      4'd8:    return 8'h80;
      4'd9:    return 8'h1b;
      4'd10:   return 8'h36;
      default: return 8'h00;
    endcase
  endfunction

endpackage

/* design/aesKeyInst.sv */
// One key word slice of the expansion chain
// Load and enable must be mutually exclusive, load wins if both rise
`timescale 1ns/1ps

module aesKeyInst (
  // Clocks and resets
  input  logic               pClk,
  input  logic               nPRst,
  input  logic               nSRst,
  // Control
  input  logic               load,
  input  logic               enable,
  // Data
  input  aesKeyPkg::keyWordT loadWord,
  input  aesKeyPkg::keyWordT xorIn,
  output aesKeyPkg::keyWordT nextTempKey,
  output aesKeyPkg::keyWordT tempKey
);
  import aesKeyPkg::*;

  // New word, also fed on to the next slice
  assign nextTempKey = xorIn ^ tempKey;

  // Word register
  always_ff @(posedge pClk or negedge nPRst)
  begin
    if (!nPRst)
      tempKey <= '0;
    // Software reset clears like power-on reset
    else if (!nSRst)
      tempKey <= '0;
    // Cipher key word at start
    else if (load)
      tempKey <= loadWord;
    // One schedule round
    else if (enable)
      tempKey <= nextTempKey;
  end

  // Controller never loads and steps in the same cycle
  loadEnableExcl: assert property (@(posedge pClk) disable iff (!nPRst)
    !(load && enable));

endmodule

/* design/keyScheduleCtrl.sv */
// Round sequencer for the AES-128 key schedule
// Start while busy is dropped, no queueing and no back-pressure
`timescale 1ns/1ps

module keyScheduleCtrl (
  // Clocks and resets
  input  logic                pClk,
  input  logic                nPRst,
  input  logic                nSRst,
  // Request
  input  logic                start,
  // To datapath
  output aesKeyPkg::ctrlS     ctrl,
  // Status of the round now held
  output logic                valid,
  output logic                done,
  output aesKeyPkg::roundIdxT roundIdx
);
  import aesKeyPkg::*;

  // Engine running, rounds 0 to 10 on display
  logic     busy;
  // Round held in the chain
  roundIdxT roundCnt;
  // Final round currently held
  logic     lastHeld;

  assign lastHeld = (roundCnt == lastRound);

  // ------------------------------------------------------------------
  // Datapath control
  // ------------------------------------------------------------------

  // Load taken only from idle
  assign ctrl.load   = start & ~busy;
  // Step while rounds remain
  assign ctrl.enable = busy & ~lastHeld;
  // Constant for the round being computed
  assign ctrl.rcon   = rconOf(roundCnt + roundIdxT'(1));

  // ------------------------------------------------------------------
  // Busy flag and round counter
  // ------------------------------------------------------------------
  always_ff @(posedge pClk or negedge nPRst)
  begin
    if (!nPRst)
    begin
      busy     <= 1'b0;
      roundCnt <= '0;
    end
    else if (!nSRst)
    begin
      busy     <= 1'b0;
      roundCnt <= '0;
    end
    else if (ctrl.load)
    begin
      busy     <= 1'b1;
      roundCnt <= '0;
    end
    else if (ctrl.enable)
      roundCnt <= roundCnt + roundIdxT'(1);
    // Round 10 shown for one cycle, then back to idle
    else if (busy)
    begin
      busy     <= 1'b0;
      roundCnt <= '0;
    end
  end

  // Status levels
  assign valid    = busy;
  assign done     = busy & lastHeld;
  assign roundIdx = roundCnt;

  // Counter bounded by the AES-128 schedule
  roundBound: assert property (@(posedge pClk) disable iff (!nPRst)
    roundCnt <= lastRound);
  // Done only flags a held key
  doneValid: assert property (@(posedge pClk) disable iff (!nPRst)
    done |-> valid);

endmodule

/* design/subWordUnit.sv */
// RotWord, SubWord and Rcon on the last key word
// Pure combinational, result is used in the same cycle
`timescale 1ns/1ps

module subWordUnit (
  input  aesKeyPkg::keyWordT lastWord,
  input  logic [7:0]         rcon,
  output aesKeyPkg::keyWordT xorIn
);
  import aesKeyPkg::*;

  // Rotated word
  keyWordU rotW;
  // Substituted word
  keyWordU subW;

  // RotWord, left by one byte
  assign rotW.word = {lastWord[23:0], lastWord[31:24]};

  // SubWord, byte by byte
  always_comb
  begin
    subW.word = '0;
    for (int i = 0; i < 4; i++)
    begin
      subW.bytes[i] = sboxByte(rotW.bytes[i]);
    end
  end

  // Rcon lands on the top byte only
  assign xorIn = subW.word ^ {rcon, 24'h00_0000};

endmodule

/* design/keyWordChain.sv */
// Four word slices forming the 128-bit round key register
// Word 0 is the most significant word of the key
`timescale 1ns/1ps

module keyWordChain (
  // Clocks and resets
  input  logic                     pClk,
  input  logic                     nPRst,
  input  logic                     nSRst,
  // Control
  input  aesKeyPkg::ctrlS          ctrl,
  // Data
  input  aesKeyPkg::keyWordT [0:3] cipherKey,
  input  aesKeyPkg::keyWordT       subWordOut,
  output aesKeyPkg::keyWordT       lastWord,
  output aesKeyPkg::keyWordT [0:3] keyWords
);
  import aesKeyPkg::*;

  // XOR input per slice
  keyWordT [0:3] chainIn;
  // New word out of each slice
  keyWordT [0:3] nextWord;

  // ------------------------------------------------------------------
  // Slices
  // ------------------------------------------------------------------
  for (genvar i = 0; i < 4; i++)
  begin : gSlice
    // Word 0 takes the SubWord result, others the new word before them
    if (i == 0)
    begin : gHead
      assign chainIn[i] = subWordOut;
    end
    else
    begin : gLink
      assign chainIn[i] = nextWord[i-1];
    end

    aesKeyInst aesKeyInst_inst (
      .pClk        (pClk),
      .nPRst       (nPRst),
      .nSRst       (nSRst),
      .load        (ctrl.load),
      .enable      (ctrl.enable),
      .loadWord    (cipherKey[i]),
      .xorIn       (chainIn[i]),
      .nextTempKey (nextWord[i]),
      .tempKey     (keyWords[i])
    );
  end

  // Stored word 3 to the SubWord unit
  assign lastWord = keyWords[3];

endmodule

/* design/aesKeyGenTop.sv */
// AES-128 key expansion, one round key per clock after start
// Consumer must take each key in its valid cycle
`timescale 1ns/1ps

module aesKeyGenTop (
  // Clocks and resets
  input  logic                pClk,
  input  logic                nPRst,
  input  logic                nSRst,
  // Request
  input  logic                start,
  input  logic [127:0]        cipherKey,
  // Round key stream
  output aesKeyPkg::roundKeyS roundKey
);
  import aesKeyPkg::*;

  ctrlS          ctrl;
  keyWordT       lastWord;
  keyWordT       xorIn;
  keyWordT [0:3] keyWords;
  logic          valid;
  logic          done;
  roundIdxT      roundIdx;

  // ------------------------------------------------------------------
  // Blocks
  // ------------------------------------------------------------------
  keyScheduleCtrl keyScheduleCtrl_inst (
    .pClk     (pClk),
    .nPRst    (nPRst),
    .nSRst    (nSRst),
    .start    (start),
    .ctrl     (ctrl),
    .valid    (valid),
    .done     (done),
    .roundIdx (roundIdx)
  );

  subWordUnit subWordUnit_inst (
    .lastWord (lastWord),
    .rcon     (ctrl.rcon),
    .xorIn    (xorIn)
  );

  // Cipher key splits into words, word 0 from the top bits
  keyWordChain keyWordChain_inst (
    .pClk       (pClk),
    .nPRst      (nPRst),
    .nSRst      (nSRst),
    .ctrl       (ctrl),
    .cipherKey  (cipherKey),
    .subWordOut (xorIn),
    .lastWord   (lastWord),
    .keyWords   (keyWords)
  );

  // Output bundle
  assign roundKey = '{valid: valid, done: done, roundIdx: roundIdx, key: keyWords};

endmodule

/* tb/aesKeyGenTb.sv */
// Testbench for the AES-128 key expansion engine
// Reference model builds its own S-box from GF(2^8) inverse and affine map
// Stops at the first mismatch, fixed seed for all random keys
`timescale 1ns/1ps

module aesKeyGenTb;
  import aesKeyPkg::*;

  localparam int halfPeriod   = 50;
  localparam int clkPeriod    = 2 * halfPeriod;
  // Known vector, 20 random, 2 with busy starts, reset pair, 3 back to back
  localparam int numRuns      = 28;
  localparam int cyclesPerRun = 30;
  localparam int timeoutNs    = (numRuns * cyclesPerRun + 40) * clkPeriod;

  logic         pClk;
  logic         nPRst;
  logic         nSRst;
  logic         start;
  logic [127:0] cipherKey;
  roundKeyS     roundKey;

  // Model state
  logic [7:0]   sbox [256];
  logic [127:0] expKeys [0:10];
  int unsigned  seedInit;

  aesKeyGenTop aesKeyGenTop_inst (
    .pClk      (pClk),
    .nPRst     (nPRst),
    .nSRst     (nSRst),
    .start     (start),
    .cipherKey (cipherKey),
    .roundKey  (roundKey)
  );

  initial pClk = 1'b0;
  always #(halfPeriod) pClk = ~pClk;

  // ------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------

  // GF(2^8) product, AES polynomial
  function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    logic [7:0] y;
    p = 8'h00;
    x = a;
    y = b;
    for (int i = 0; i < 8; i++)
    begin
      if (y[0])
        p = p ^ x;
      x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
      y = {1'b0, y[7:1]};
    end
    return p;
  endfunction

  // Brute force inverse, zero maps to zero
  function automatic logic [7:0] gfInv(input logic [7:0] a);
    for (int c = 1; c < 256; c++)
    begin
      if (gfMul(a, 8'(c)) == 8'h01)
        return 8'(c);
    end
    return 8'h00;
  endfunction

  // Affine step of FIPS-197 5.1.1
  function automatic logic [7:0] affineMap(input logic [7:0] b);
    return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
           ^ {b[3:0], b[7:4]} ^ 8'h63;
  endfunction

  task automatic buildSbox();
    for (int i = 0; i < 256; i++)
    begin
      sbox[i] = affineMap(gfInv(8'(i)));
    end
  endtask

  // RotWord then SubWord
  function automatic logic [31:0] subRotWord(input logic [31:0] w);
    logic [31:0] r;
    r = {w[23:0], w[31:24]};
    return {sbox[r[31:24]], sbox[r[23:16]], sbox[r[15:8]], sbox[r[7:0]]};
  endfunction

  // Full AES-128 expansion into expKeys
  task automatic expandKey(input logic [127:0] key);
    logic [31:0] w [0:43];
    logic [31:0] temp;
    logic [7:0]  rc;
    rc   = 8'h01;
    w[0] = key[127:96];
    w[1] = key[95:64];
    w[2] = key[63:32];
    w[3] = key[31:0];
    for (int i = 4; i < 44; i++)
    begin
      temp = w[i-1];
      if (i % 4 == 0)
      begin
        temp = subRotWord(temp) ^ {rc, 24'h00_0000};
        rc   = {rc[6:0], 1'b0} ^ (rc[7] ? 8'h1b : 8'h00);
      end
      w[i] = w[i-4] ^ temp;
    end
    for (int r = 0; r <= 10; r++)
    begin
      expKeys[r] = {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
    end
  endtask

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------

  // Next rising edge, then the drive and sample point
  task automatic stepCycle();
    @(posedge pClk);
    #1;
  endtask

  task automatic checkEq(input logic [127:0] expected, input logic [127:0] actual,
                         input string what);
    if (actual !== expected)
    begin
      $display("Fail at %0d ns: %s, expected %h, got %h", $time, what, expected, actual);
      $display("test failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  function automatic logic [127:0] randKey();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  // One held round against the model
  task automatic checkRound(input int n);
    checkEq(128'(1), 128'(roundKey.valid), $sformatf("valid in round %0d", n));
    checkEq(128'(n), 128'(roundKey.roundIdx), $sformatf("index of round %0d", n));
    checkEq(expKeys[n], roundKey.key, $sformatf("key of round %0d", n));
    checkEq(128'(n == 10), 128'(roundKey.done), $sformatf("done in round %0d", n));
  endtask

  // Full run from idle, optional start pokes while busy
  task automatic runKey(input logic [127:0] key, input bit pokeBusy);
    expandKey(key);
    start     = 1'b1;
    cipherKey = key;
    stepCycle();
    start     = 1'b0;
    cipherKey = randKey();
    for (int n = 0; n <= 10; n++)
    begin
      checkRound(n);
      // Busy engine must drop these
      if (pokeBusy)
      begin
        start     = 1'($urandom());
        cipherKey = randKey();
      end
      stepCycle();
      start = 1'b0;
    end
    checkEq(128'(0), 128'(roundKey.valid), "valid after round 10");
    checkEq(128'(0), 128'(roundKey.done), "done after round 10");
  endtask

  // Software reset part way through a run
  task automatic resetMidRun(input logic [127:0] key, input int rounds);
    expandKey(key);
    start     = 1'b1;
    cipherKey = key;
    stepCycle();
    start     = 1'b0;
    for (int n = 0; n < rounds; n++)
    begin
      checkRound(n);
      stepCycle();
    end
    nSRst = 1'b0;
    stepCycle();
    checkEq(128'(0), 128'(roundKey.valid), "valid after software reset");
    checkEq(128'(0), 128'(roundKey.done), "done after software reset");
    checkEq(128'(0), 128'(roundKey.roundIdx), "round index after software reset");
    checkEq(128'(0), roundKey.key, "key after software reset");
    nSRst = 1'b1;
    stepCycle();
    // Engine stays idle without a new start
    checkEq(128'(0), 128'(roundKey.valid), "valid idle after software reset");
  endtask

  // ------------------------------------------------------------------
  // Watchdog
  // ------------------------------------------------------------------
  initial
  begin
    #(timeoutNs);
    $display("Timeout: the key runs did not finish in the allowed time");
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------
  initial
  begin
    seedInit   = $urandom(32'hd2e8);
    nPRst      = 1'b0;
    nSRst      = 1'b1;
    start      = 1'b0;
    cipherKey  = '0;
    buildSbox();

    repeat (4) @(posedge pClk);
    #1;
    nPRst = 1'b1;
    checkEq(128'(0), 128'(roundKey.valid), "valid after power-on reset");
    checkEq(128'(0), roundKey.key, "key after power-on reset");
    stepCycle();

    // FIPS-197 appendix A.1 vector
    runKey(128'h2b7e151628aed2a6abf7158809cf4f3c, 1'b0);
    checkEq(128'hd014f9a8c9ee2589e13f0cc8b6630ca6, expKeys[10], "model round 10 key");

    // Random keys
    repeat (20) runKey(randKey(), 1'b0);

    // Start pulses while busy
    repeat (2) runKey(randKey(), 1'b1);

    // Software reset, then a normal run
    resetMidRun(randKey(), 5);
    runKey(randKey(), 1'b0);

    // Start on the cycle right after done
    repeat (3) runKey(randKey(), 1'b0);

    $display("test passed");
    $finish;
  end

endmodule

/* all.f */
design/aesKeyPkg.sv
design/aesKeyInst.sv
design/keyScheduleCtrl.sv
design/subWordUnit.sv
design/keyWordChain.sv
design/aesKeyGenTop.sv
tb/aesKeyGenTb.sv

/* Makefile */
# Verilator build and run for the AES-128 key expansion testbench

VERILATOR ?= verilator
TOP       ?= aesKeyGenTb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= test passed

SIM_BIN = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# Build the simulation binary from the file list
compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

# Run and search the output for the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
	  exit 0; \
	else \
	  echo "Simulation did not report a pass"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJDIR)
